// File: design/vga_consts.svh
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// horizontal geometry, pixels per line
`define H_ACTIVE          64
`define H_TOTAL           80
`define HSYNC_START       68
`define HSYNC_END         76

// vertical geometry, lines per frame
`define V_ACTIVE          32
`define V_TOTAL           40
`define VSYNC_START       34
`define VSYNC_END         36

// screen in character cells
`define CELL_COLS         8
`define CELL_ROWS         4

`define PIPE_DELAY        2   // counters -> rgb, in clocks
`define CURSOR_FIRST_ROW  6   // underline covers glyph rows 6..7

`endif

// File: design/vga_pkg.sv
package vga_pkg;

    // character code, or four packed 2-bit pixels in graphics mode
    typedef logic [7:0]  glyph_t;

    typedef logic [2:0]  cell_pos_t;   // row/col inside an 8x8 glyph
    typedef logic [3:0]  ega_color_t;  // text attribute colour index
    typedef logic [1:0]  cga_pixel_t;  // graphics pixel value
    typedef logic [11:0] rgb_t;        // 4 bits per channel, r in msbs

    typedef logic [4:0]  cell_addr_t;  // row-major cell index

    // {bg[3:0], fg[3:0], glyph[7:0]}
    typedef logic [15:0] cell_word_t;

    typedef logic [10:0] font_addr_t;  // glyph * 8 + row

    typedef logic [6:0]  hcount_t;
    typedef logic [5:0]  vcount_t;

    // vertical region of the current line
    typedef enum logic [1:0] {
        VS_ACTIVE,
        VS_FRONT,
        VS_SYNC,
        VS_BACK
    } sync_state_t;

endpackage

// File: design/pixel_if.sv
// one pixel per clock from cell fetch to colour stage, no handshake
interface pixel_if;

    logic                active;          // visible area
    vga_pkg::glyph_t     glyph;
    vga_pkg::cell_pos_t  glyph_row;
    vga_pkg::cell_pos_t  glyph_col;
    vga_pkg::ega_color_t foreground;
    vga_pkg::ega_color_t background;
    logic                render_cursor;   // invert font bit
    vga_pkg::cga_pixel_t graphics_pixel;

    modport fetch (
        output active, glyph, glyph_row, glyph_col,
        output foreground, background,
        output render_cursor, graphics_pixel
    );

    modport color (
        input  active, glyph, glyph_row, glyph_col,
        input  foreground, background,
        input  render_cursor, graphics_pixel
    );

endinterface

// File: design/video_timing.sv
`include "vga_consts.svh"

module video_timing (
    input  logic             clk,
    input  logic             rst,
    output vga_pkg::hcount_t h,
    output vga_pkg::vcount_t v,
    output logic             active,
    output logic             hsync,
    output logic             vsync,
    output logic             de
);

    vga_pkg::sync_state_t   region;    // steps once per line
    vga_pkg::vcount_t       v_next;
    logic                   line_end;
    logic                   hs_now;
    logic [`PIPE_DELAY-1:0] hs_pipe;
    logic [`PIPE_DELAY-1:0] vs_pipe;
    logic [`PIPE_DELAY-1:0] de_pipe;

    assign line_end = (h == vga_pkg::hcount_t'(`H_TOTAL - 1));
    assign v_next   = (v == vga_pkg::vcount_t'(`V_TOTAL - 1)) ? '0 : v + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            h <= '0;
            v <= '0;
        end else if (line_end) begin
            h <= '0;
            v <= v_next;   // wraps at V_TOTAL
        end else begin
            h <= h + 1'b1;
        end
    end

    // region fsm, looks ahead at the line about to start
    always_ff @(posedge clk) begin
        if (rst) begin
            region <= vga_pkg::VS_ACTIVE;
        end else if (line_end) begin
            case (region)
                vga_pkg::VS_ACTIVE:
                    if (v_next == vga_pkg::vcount_t'(`V_ACTIVE)) region <= vga_pkg::VS_FRONT;
                vga_pkg::VS_FRONT:
                    if (v_next == vga_pkg::vcount_t'(`VSYNC_START)) region <= vga_pkg::VS_SYNC;
                vga_pkg::VS_SYNC:
                    if (v_next == vga_pkg::vcount_t'(`VSYNC_END)) region <= vga_pkg::VS_BACK;
                default:
                    if (v_next == '0) region <= vga_pkg::VS_ACTIVE;   // back porch done
            endcase
        end
    end

    assign active = (h < vga_pkg::hcount_t'(`H_ACTIVE)) && (region == vga_pkg::VS_ACTIVE);
    assign hs_now = (h >= vga_pkg::hcount_t'(`HSYNC_START)) &&
                    (h < vga_pkg::hcount_t'(`HSYNC_END));

    // delay sync/de so they land with the rgb of the same pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_pipe <= '0;
            vs_pipe <= '0;
            de_pipe <= '0;
        end else begin
            hs_pipe <= {hs_pipe[`PIPE_DELAY-2:0], hs_now};
            vs_pipe <= {vs_pipe[`PIPE_DELAY-2:0], region == vga_pkg::VS_SYNC};
            de_pipe <= {de_pipe[`PIPE_DELAY-2:0], active};
        end
    end

    assign hsync = hs_pipe[`PIPE_DELAY-1];
    assign vsync = vs_pipe[`PIPE_DELAY-1];
    assign de    = de_pipe[`PIPE_DELAY-1];

    a_counters_in_range: assert property (@(posedge clk) disable iff (rst)
        h < vga_pkg::hcount_t'(`H_TOTAL) && v < vga_pkg::vcount_t'(`V_TOTAL));

    // delayed vsync must have drained before the visible lines start
    a_no_vsync_in_active: assert property (@(posedge clk) disable iff (rst)
        region == vga_pkg::VS_ACTIVE |-> !vsync);

endmodule

// File: design/cell_fetch.sv
`include "vga_consts.svh"

module cell_fetch (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::hcount_t    h,
    input  vga_pkg::vcount_t    v,
    input  logic                active,
    input  logic                cell_we,
    input  vga_pkg::cell_addr_t cell_addr,
    input  vga_pkg::cell_word_t cell_data,
    input  logic                cursor_enable,
    input  vga_pkg::cell_addr_t cursor_pos,
    pixel_if.fetch              pix
);

    // character/attribute store with one word per cell
    vga_pkg::cell_word_t cell_ram [`CELL_COLS * `CELL_ROWS];

    vga_pkg::cell_addr_t rd_addr;
    vga_pkg::cell_pos_t  row;
    vga_pkg::cell_pos_t  col;
    logic                cursor_hit;

    vga_pkg::cell_word_t cell_q;
    vga_pkg::cell_pos_t  row_q;
    vga_pkg::cell_pos_t  col_q;
    logic                active_q;
    logic                cursor_q;
    vga_pkg::cga_pixel_t gfx_pix;

    // cell index v/8 * cols + h/8
    // garbage in blanking but never shown
    assign rd_addr = vga_pkg::cell_addr_t'((v / 8) * `CELL_COLS + (h / 8));
    assign row     = v[2:0];
    assign col     = h[2:0];

    // underline on the bottom glyph rows of the cursor cell
    assign cursor_hit = cursor_enable && (rd_addr == cursor_pos) &&
                        (row >= vga_pkg::cell_pos_t'(`CURSOR_FIRST_ROW));

    // display read sees the old word on a same-edge host write
    always_ff @(posedge clk) begin
        if (cell_we)
            cell_ram[cell_addr] <= cell_data;
        cell_q <= cell_ram[rd_addr];
        row_q  <= row;
        col_q  <= col;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            cursor_q <= 1'b0;
        end else begin
            active_q <= active;
            cursor_q <= cursor_hit;
        end
    end

    // four 2-bit fields per graphics byte with the msbs leftmost
    // each field covers 2 screen pixels
    always_comb begin
        case (col_q[2:1])
            2'd0:    gfx_pix = cell_q[7:6];
            2'd1:    gfx_pix = cell_q[5:4];
            2'd2:    gfx_pix = cell_q[3:2];
            default: gfx_pix = cell_q[1:0];
        endcase
    end

    assign pix.active         = active_q;
    assign pix.glyph          = cell_q[7:0];
    assign pix.glyph_row      = row_q;
    assign pix.glyph_col      = col_q;
    assign pix.foreground     = cell_q[11:8];    // attr low nibble
    assign pix.background     = cell_q[15:12];   // attr high nibble
    assign pix.render_cursor  = cursor_q;
    assign pix.graphics_pixel = gfx_pix;

endmodule

// File: design/font_color_lut.sv
module font_color_lut (
    input  logic                clk,
    input  logic                rst,
    pixel_if.color              pix,
    input  logic                font_we,
    input  vga_pkg::font_addr_t font_addr,
    input  vga_pkg::glyph_t     font_data,
    input  logic                graphics_enabled,
    input  logic                bright_colors,
    input  logic                palette_sel,
    input  vga_pkg::ega_color_t background_color,
    output vga_pkg::rgb_t       rgb
);

    // 16 ega colours
    localparam vga_pkg::rgb_t TEXT_LUT [16] = '{
        12'h000,   // black
        12'h00a,   // blue
        12'h0a0,   // green
        12'h0aa,   // cyan
        12'ha00,   // red
        12'ha0a,   // magenta
        12'ha50,   // brown
        12'haaa,   // white
        12'h555,   // gray
        12'h55f,   // bright blue
        12'h5f5,   // bright green
        12'h5ff,   // bright cyan
        12'hf55,   // bright red
        12'hf5f,   // bright magenta
        12'hff5,   // yellow
        12'hfff    // bright white
    };

    // indexed by {palette_sel, bright_colors, pixel}
    // entry 0 of each palette is never read
    localparam vga_pkg::rgb_t GFX_LUT [16] = '{
        12'h000,   // palette 0
        12'h0a0,   // green
        12'ha00,   // red
        12'ha50,   // brown
        12'h000,   // bright palette 0
        12'h5f5,
        12'hf55,
        12'hff5,
        12'h000,   // palette 1
        12'h0aa,   // cyan
        12'ha0a,   // magenta
        12'haaa,   // white
        12'h000,   // bright palette 1
        12'h5ff,
        12'hf5f,
        12'hfff
    };

    // 256 glyphs x 8 rows with msb as leftmost pixel
    vga_pkg::glyph_t font_ram [1 << $bits(vga_pkg::font_addr_t)];

    vga_pkg::font_addr_t rd_addr;
    vga_pkg::glyph_t     font_row;
    logic                font_bit;
    vga_pkg::rgb_t       gfx_rgb;

    assign rd_addr  = {pix.glyph, pix.glyph_row};
    assign font_row = font_ram[rd_addr];             // old data on same-cycle write
    assign font_bit = font_row[3'd7 - pix.glyph_col];

    // pixel 0 falls back to the selectable background
    assign gfx_rgb = (pix.graphics_pixel == '0) ? TEXT_LUT[background_color] :
                     GFX_LUT[{palette_sel, bright_colors, pix.graphics_pixel}];

    always_ff @(posedge clk) begin
        if (font_we)
            font_ram[font_addr] <= font_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else if (!pix.active) begin
            rgb <= '0;                                // blanking is black
        end else if (graphics_enabled) begin
            rgb <= gfx_rgb;
        end else if (font_bit ^ pix.render_cursor) begin
            rgb <= TEXT_LUT[pix.foreground];
        end else begin
            rgb <= TEXT_LUT[pix.background];
        end
    end

endmodule

// File: design/display_top.sv
module display_top (
    input  logic                clk,
    input  logic                rst,
    // host cell port
    input  logic                cell_we,
    input  vga_pkg::cell_addr_t cell_addr,
    input  vga_pkg::cell_word_t cell_data,
    // host font port
    input  logic                font_we,
    input  vga_pkg::font_addr_t font_addr,
    input  vga_pkg::glyph_t     font_data,
    // mode levels
    input  logic                graphics_enabled,
    input  logic                bright_colors,
    input  logic                palette_sel,
    input  vga_pkg::ega_color_t background_color,
    input  logic                cursor_enable,
    input  vga_pkg::cell_addr_t cursor_pos,
    // video out
    output logic [3:0]          r,
    output logic [3:0]          g,
    output logic [3:0]          b,
    output logic                hsync,
    output logic                vsync,
    output logic                de
);

    vga_pkg::hcount_t h;
    vga_pkg::vcount_t v;
    logic             active;   // undelayed, feeds fetch

    pixel_if u_pix ();

    video_timing u_timing (
        .clk    (clk),
        .rst    (rst),
        .h      (h),
        .v      (v),
        .active (active),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de)
    );

    cell_fetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .h             (h),
        .v             (v),
        .active        (active),
        .cell_we       (cell_we),
        .cell_addr     (cell_addr),
        .cell_data     (cell_data),
        .cursor_enable (cursor_enable),
        .cursor_pos    (cursor_pos),
        .pix           (u_pix.fetch)
    );

    font_color_lut u_color (
        .clk              (clk),
        .rst              (rst),
        .pix              (u_pix.color),
        .font_we          (font_we),
        .font_addr        (font_addr),
        .font_data        (font_data),
        .graphics_enabled (graphics_enabled),
        .bright_colors    (bright_colors),
        .palette_sel      (palette_sel),
        .background_color (background_color),
        .rgb              ({r, g, b})      // r in the top nibble
    );

endmodule

// File: verif/tb_display.sv
`include "vga_consts.svh"

module tb_display;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;
    localparam int WATCH_LIMIT  = 6 * FRAME_CYCLES + 200;   // per test

    logic                clk = 1'b0;
    logic                rst;
    logic                cell_we;
    vga_pkg::cell_addr_t cell_addr;
    vga_pkg::cell_word_t cell_data;
    logic                font_we;
    vga_pkg::font_addr_t font_addr;
    vga_pkg::glyph_t     font_data;
    logic                graphics_enabled;
    logic                bright_colors;
    logic                palette_sel;
    vga_pkg::ega_color_t background_color;
    logic                cursor_enable;
    vga_pkg::cell_addr_t cursor_pos;
    logic [3:0]          r;
    logic [3:0]          g;
    logic [3:0]          b;
    logic                hsync;
    logic                vsync;
    logic                de;
    vga_pkg::rgb_t       rgb_out;

    // model of host writes
    vga_pkg::cell_word_t cells [`CELL_COLS * `CELL_ROWS];
    vga_pkg::glyph_t     font [2048];

    // the 16 ega colours
    vga_pkg::rgb_t ega_lut [16] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa, 12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff, 12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

    int    cycle_count = 0;
    int    test_start  = 0;   // cycle the current test began
    string cur_test    = "reset";

    always #4 clk = ~clk;

    assign rgb_out = {r, g, b};

    display_top u_dut (.*);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count - test_start > WATCH_LIMIT) begin
            $display("timeout: %s ran more than %0d cycles", cur_test, WATCH_LIMIT);
            $display("ERRORS FOUND");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic start_test(string name);
        cur_test   = name;
        test_start = cycle_count;
    endtask

    task automatic check_rgb(string name, vga_pkg::rgb_t expected, vga_pkg::rgb_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic write_cell(vga_pkg::cell_addr_t addr, vga_pkg::cell_word_t data);
        @(negedge clk);
        cell_we     = 1'b1;
        cell_addr   = addr;
        cell_data   = data;
        cells[addr] = data;
    endtask

    task automatic write_font_row(vga_pkg::font_addr_t addr, vga_pkg::glyph_t data);
        @(negedge clk);
        font_we    = 1'b1;
        font_addr  = addr;
        font_data  = data;
        font[addr] = data;
    endtask

    task automatic release_host();
        @(negedge clk);
        cell_we = 1'b0;
        font_we = 1'b0;
    endtask

    // expected colour of visible pixel (x, y) under the current mode levels
    function automatic vga_pkg::rgb_t expected_rgb(int x, int y);
        vga_pkg::cell_addr_t idx;
        vga_pkg::cell_word_t word;
        vga_pkg::glyph_t     row_bits;
        int                  field;
        logic                lit;
        idx  = vga_pkg::cell_addr_t'((y / 8) * `CELL_COLS + x / 8);
        word = cells[idx];
        if (graphics_enabled) begin
            field = (int'(word[7:0]) >> (6 - 2 * ((x % 8) / 2))) & 3;   // leftmost field first
            if (field == 0)
                return ega_lut[background_color];
            // cga colours are ega 2,4,6 / 3,5,7, plus 8 when bright
            return ega_lut[4'(2 * field + int'(palette_sel) + 8 * int'(bright_colors))];
        end
        row_bits = font[{word[7:0], 3'(y % 8)}];   // glyph * 8 + row
        lit      = row_bits[3'(7 - x % 8)];        // msb is leftmost
        if (cursor_enable && idx == cursor_pos && (y % 8) >= `CURSOR_FIRST_ROW)
            lit = !lit;
        return lit ? ega_lut[word[11:8]] : ega_lut[word[15:12]];
    endfunction

    // returns on the falling clock where delayed vsync has just dropped
    task automatic wait_frame_start();
        logic prev;
        prev = vsync;
        @(negedge clk);
        while (!(prev && !vsync)) begin
            prev = vsync;
            @(negedge clk);
        end
    endtask

    // one full frame, row-major by de count; blanking must stay black
    task automatic check_frame(string name);
        int n;
        n = 0;
        wait_frame_start();
        while (n < FRAME_PIXELS) begin
            if (de) begin
                check_rgb($sformatf("%s at (%0d,%0d)", name, n % `H_ACTIVE, n / `H_ACTIVE),
                          expected_rgb(n % `H_ACTIVE, n / `H_ACTIVE), rgb_out);
                n++;
            end else begin
                check_rgb({name, " blanking"}, '0, rgb_out);
            end
            if (n < FRAME_PIXELS)
                @(negedge clk);
        end
    endtask

    task automatic reset_idle();
        int n_de;
        int n_hs;
        int n_vs;
        start_test("reset_idle");
        n_de = 0;
        n_hs = 0;
        n_vs = 0;
        repeat (2) begin   // pipeline still flushing
            check_count("reset_idle sync/de", 0, int'({hsync, vsync, de}));
            check_rgb("reset_idle rgb", '0, rgb_out);
            @(negedge clk);
        end
        repeat (FRAME_CYCLES) begin   // any full-frame window
            n_de += int'(de);
            n_hs += int'(hsync);
            n_vs += int'(vsync);
            if (!de)
                check_rgb("reset_idle blanking", '0, rgb_out);
            @(negedge clk);
        end
        check_count("reset_idle de", FRAME_PIXELS, n_de);
        check_count("reset_idle hsync", (`HSYNC_END - `HSYNC_START) * `V_TOTAL, n_hs);
        check_count("reset_idle vsync", (`VSYNC_END - `VSYNC_START) * `H_TOTAL, n_vs);
    endtask

    task automatic text_frame();
        start_test("text_frame");
        for (int a = 0; a < 2048; a++)
            write_font_row(vga_pkg::font_addr_t'(a), vga_pkg::glyph_t'($urandom));
        for (int c = 0; c < `CELL_COLS * `CELL_ROWS; c++)
            write_cell(vga_pkg::cell_addr_t'(c), vga_pkg::cell_word_t'($urandom));
        release_host();
        check_frame("text_frame");
    endtask

    task automatic cursor_underline();
        start_test("cursor_underline");
        @(negedge clk);
        cursor_pos    = vga_pkg::cell_addr_t'($urandom);
        cursor_enable = 1'b1;
        check_frame("cursor_underline");
        cursor_enable = 1'b0;   // still in blanking here
    endtask

    task automatic graphics_palettes();
        start_test("graphics_palettes");
        @(negedge clk);
        graphics_enabled = 1'b1;
        background_color = vga_pkg::ega_color_t'($urandom);
        for (int sel = 0; sel < 4; sel++) begin
            palette_sel   = sel[1];
            bright_colors = sel[0];
            check_frame($sformatf("graphics_palettes sel=%0d", sel));
        end
        graphics_enabled = 1'b0;
    endtask

    task automatic live_rewrite();
        vga_pkg::cell_addr_t idx;
        vga_pkg::cell_word_t data;
        start_test("live_rewrite");
        repeat (2) begin
            idx  = vga_pkg::cell_addr_t'($urandom);
            data = vga_pkg::cell_word_t'($urandom);
            if (data == cells[idx])
                data = ~data;   // force a real change
            write_cell(idx, data);
            release_host();
            check_frame("live_rewrite");
        end
    endtask

    initial begin
        rst              = 1'b1;
        cell_we          = 1'b0;
        cell_addr        = '0;
        cell_data        = '0;
        font_we          = 1'b0;
        font_addr        = '0;
        font_data        = '0;
        graphics_enabled = 1'b0;
        bright_colors    = 1'b0;
        palette_sel      = 1'b0;
        background_color = '0;
        cursor_enable    = 1'b0;
        cursor_pos       = '0;
        void'($urandom(32'h52f3508d));
        repeat (3) @(negedge clk);
        rst = 1'b0;
        reset_idle();
        text_frame();
        cursor_underline();
        graphics_palettes();
        live_rewrite();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: build.f
+incdir+design
design/vga_pkg.sv
design/pixel_if.sv
design/video_timing.sv
design/cell_fetch.sv
design/font_color_lut.sv
design/display_top.sv
verif/tb_display.sv

// File: Makefile
.PHONY: sim clean

# builds tb_display into obj_dir, then looks for the pass line in the output
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_display -f build.f -o tb_display
	@out=$$(./obj_dir/tb_display); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
